// File: build.f
logic/led_pkg.sv
logic/led_wb_slave.sv
logic/pixel_ram.sv
logic/ws2812_transmitter.sv
logic/led_strip_top.sv
dv/led_strip_properties.sv
dv/led_strip_tb.sv

// File: dv/led_strip_properties.sv
`timescale 1ns/1ps

module led_strip_properties #(
  parameter int clk_hz   = 27_000_000,
  parameter int reset_us = 300
) (
  input logic             clk,
  input logic             reset_n,
  input led_pkg::wb_req_t wb_req,
  input led_pkg::wb_rsp_t wb_rsp,
  input logic             busy
);

  localparam int gap_len = reset_us * (clk_hz / 1_000_000);

  logic req;
  int   idle_cycles;  // idle cycles since busy, saturating at the gap

  assign req = wb_req.cyc && wb_req.stb;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      idle_cycles <= 0;
    end else if (busy) begin
      idle_cycles <= 0;
    end else if (idle_cycles < gap_len) begin
      idle_cycles <= idle_cycles + 1;
    end
  end

  // a fresh request is acked on the next edge
  ack_follows_req: assert property (
    @(posedge clk) disable iff (!reset_n) req && !$past(req) |=> wb_rsp.ack
  ) else $error("no ack one cycle after a new bus request");

  ack_single_cycle: assert property (
    @(posedge clk) disable iff (!reset_n) wb_rsp.ack |=> !wb_rsp.ack
  ) else $error("ack held high for two cycles");

  ack_needs_req: assert property (
    @(posedge clk) disable iff (!reset_n) wb_rsp.ack |-> $past(req)
  ) else $error("ack without a bus request");

  // every frame starts only after a full reset gap
  gap_before_frame: assert property (
    @(posedge clk) disable iff (!reset_n) $rose(busy) |-> idle_cycles >= gap_len
  ) else $error("frame started after an idle run shorter than the reset gap");

endmodule

bind led_strip_top led_strip_properties #(
  .clk_hz   (clk_hz),
  .reset_us (reset_us)
) i_properties (
  .clk     (clk),
  .reset_n (reset_n),
  .wb_req  (wb_req),
  .wb_rsp  (wb_rsp),
  .busy    (busy)
);

// File: dv/led_strip_tb.sv
`timescale 1ns/1ps

module led_strip_tb;

  import led_pkg::*;

  localparam int clk_hz       = 20_000_000;
  localparam int reset_us     = 5;
  localparam int clk_mhz      = clk_hz / 1_000_000;
  localparam int t0h          = (40 * clk_mhz + 50) / 100;  // 0.40 us, rounded
  localparam int t1h          = (85 * clk_mhz + 50) / 100;  // 0.85 us, rounded
  localparam int gap_len      = reset_us * clk_mhz;
  localparam int bit_cycles   = t0h + t1h + 1;  // high, low and the next_bit step
  localparam int bit_midpoint = (t0h + t1h) / 2;
  localparam int bus_timeout  = 16;
  localparam int start_timeout = 1 + 4 * 24 * bit_cycles + 3 * gap_len;

  logic    clk;
  logic    reset_n;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  logic    ws2812;

  integer seed         = 32'h6b88a4e4;
  int     errors       = 0;
  int     tests_run    = 0;
  int     tests_failed = 0;
  int     cycle        = 0;
  string  cur_test     = "reset";
  pixel_t rx_pix [4];      // decoded pixels of the last frame
  int     pulse_len [96];  // high time of every decoded bit
  int     lead_low;        // low cycles seen before the last frame

  led_strip_top #(
    .clk_hz   (clk_hz),
    .reset_us (reset_us)
  ) i_dut (
    .clk     (clk),
    .reset_n (reset_n),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .ws2812  (ws2812)
  );

  always #4 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic wb_data_t ctrl_word(input logic en, input pixel_count_t count);
    return {16'h0000, count, 7'h00, en};
  endfunction

  function automatic int frame_cycles(input int n_pix);
    return 1 + n_pix * 24 * bit_cycles;  // fetch plus all bits
  endfunction

  task automatic expect_equal(input string what, input wb_data_t expected,
                              input wb_data_t actual);
    if (expected !== actual) begin
      $display("error %s: %s expected %h actual %h", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic report_failure(input string why);
    $display("%s: %s", cur_test, why);
    errors++;
  endtask

  task automatic finish_test(input int start_errors);
    tests_run++;
    if (errors > start_errors) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, errors - start_errors);
    end else begin
      $display("test %s: ok", cur_test);
    end
  endtask

  task automatic wishbone_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat_w,
                                output wb_data_t dat_r);
    int waited;
    @(negedge clk);
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = we;
    wb_req.adr   = adr;
    wb_req.dat_w = dat_w;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_rsp.ack && waited < bus_timeout);
    dat_r = wb_rsp.dat_r;
    if (!wb_rsp.ack) begin
      report_failure($sformatf("no ack from the bus at word %0d", adr));
    end
    wb_req = '0;  // stb low for a cycle before the next access
  endtask

  task automatic write_word(input wb_addr_t adr, input wb_data_t data);
    wb_data_t unused;
    wishbone_cycle(1'b1, adr, data, unused);
  endtask

  task automatic read_word(input wb_addr_t adr, output wb_data_t data);
    wishbone_cycle(1'b0, adr, '0, data);
  endtask

  // returns on the first high sample after a low run long enough for a gap
  task automatic wait_frame_start(input int limit);
    int  low_run;
    int  waited;
    logic found;
    low_run = 0;
    waited  = 0;
    found   = 1'b0;
    while (!found && waited < limit) begin
      @(negedge clk);
      waited++;
      if (!ws2812) begin
        low_run++;
      end else if (low_run >= gap_len / 2) begin
        found    = 1'b1;
        lead_low = low_run;
      end else begin
        low_run = 0;
      end
    end
    if (!found) begin
      report_failure("no frame started on the serial line");
    end
  endtask

  task automatic wait_high(input int limit);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!ws2812 && waited < limit);
    if (!ws2812) begin
      report_failure("serial line stuck low inside a frame");
    end
  endtask

  // line is high at the current sample, returns at the first low sample
  task automatic measure_high(output int len);
    len = 1;
    do begin
      @(negedge clk);
      if (ws2812) begin
        len++;
      end
    end while (ws2812 && len < 4 * t1h);
    if (ws2812) begin
      report_failure("serial line stuck high");
    end
  endtask

  task automatic decode_frame(input int n_pix, input int limit);
    int len;
    int idx;
    wait_frame_start(limit);
    for (int p = 0; p < n_pix; p++) begin
      for (int b = 0; b < 24; b++) begin
        idx = p * 24 + b;
        if (idx != 0) begin
          wait_high(2 * t1h);
        end
        measure_high(len);
        pulse_len[idx] = len;
        rx_pix[p] = {rx_pix[p][22:0], len > bit_midpoint};  // msb first
      end
    end
  endtask

  // disable, then wait until no frame can still be pending
  task automatic stop_chain();
    wb_data_t status;
    int quiet_from;
    int deadline;
    write_word(reg_ctrl, '0);
    quiet_from = cycle;
    deadline   = cycle + frame_cycles(4) + 4 * gap_len;
    do begin
      read_word(reg_status, status);
      if (status[status_busy_bit]) begin
        quiet_from = cycle;
      end
    end while (cycle - quiet_from < 2 * gap_len && cycle < deadline);
    if (cycle - quiet_from < 2 * gap_len) begin
      report_failure("transmitter did not go idle after disable");
    end
  endtask

  task automatic access_registers();
    wb_data_t rdata;
    int start_errors;
    cur_test     = "register access";
    start_errors = errors;
    read_word(reg_status, rdata);
    expect_equal("status after reset", 32'h0, rdata);
    write_word(reg_ctrl, ctrl_word(1'b0, 8'ha5));
    read_word(reg_ctrl, rdata);
    expect_equal("ctrl readback", ctrl_word(1'b0, 8'ha5), rdata);
    write_word(reg_ctrl, ctrl_word(1'b1, 8'h00));  // enabled but empty chain
    read_word(reg_ctrl, rdata);
    expect_equal("ctrl readback", ctrl_word(1'b1, 8'h00), rdata);
    write_word(10'd77, 32'hffff_ffff);
    read_word(reg_ctrl, rdata);
    expect_equal("ctrl after unmapped write", ctrl_word(1'b1, 8'h00), rdata);
    read_word(10'd77, rdata);
    expect_equal("unmapped read", 32'h0, rdata);
    write_word(reg_ctrl, '0);
    finish_test(start_errors);
  endtask

  task automatic send_random_frame();
    pixel_t sent [4];
    int start_errors;
    cur_test     = "frame content";
    start_errors = errors;
    stop_chain();
    for (int i = 0; i < 4; i++) begin
      sent[i] = pixel_t'($random(seed));
      write_word(pixel_base + wb_addr_t'(i), {8'h00, sent[i]});
    end
    write_word(reg_ctrl, ctrl_word(1'b1, 8'd4));
    decode_frame(4, start_timeout);
    for (int i = 0; i < 96; i++) begin
      expect_equal($sformatf("pixel %0d bit %0d", i / 24, 23 - i % 24),
                   32'(sent[i / 24][23 - i % 24]), 32'(rx_pix[i / 24][23 - i % 24]));
    end
    finish_test(start_errors);
  endtask

  task automatic measure_bit_timing();
    pixel_t sent [2];
    int exp_len;
    int start_errors;
    cur_test     = "bit timing";
    start_errors = errors;
    sent[0] = 24'hff0000;
    sent[1] = 24'h00ff00;
    stop_chain();
    write_word(pixel_base, {8'h00, sent[0]});
    write_word(pixel_base + 10'd1, {8'h00, sent[1]});
    write_word(reg_ctrl, ctrl_word(1'b1, 8'd2));
    decode_frame(2, start_timeout);
    for (int i = 0; i < 48; i++) begin
      exp_len = sent[i / 24][23 - i % 24] ? t1h : t0h;
      expect_equal($sformatf("high time of bit %0d", i), exp_len, pulse_len[i]);
    end
    finish_test(start_errors);
  endtask

  task automatic repeat_frames();
    pixel_t first [2];
    wb_data_t status;
    frame_count_t count_before;
    frame_count_t delta;
    int waited;
    int start_errors;
    cur_test     = "reset gap and repetition";
    start_errors = errors;
    read_word(reg_status, status);
    count_before = status[status_frame_lsb +: 16];
    decode_frame(2, start_timeout);
    first[0] = rx_pix[0];
    first[1] = rx_pix[1];
    decode_frame(2, start_timeout);  // the frame right after
    if (lead_low < gap_len) begin
      report_failure($sformatf("gap between frames only %0d cycles long", lead_low));
    end
    expect_equal("second frame pixel 0", 32'(first[0]), 32'(rx_pix[0]));
    expect_equal("second frame pixel 1", 32'(first[1]), 32'(rx_pix[1]));
    waited = 0;
    do begin
      read_word(reg_status, status);
      delta = status[status_frame_lsb +: 16] - count_before;
      waited++;
    end while (delta < 16'd2 && waited < gap_len);
    if (delta < 16'd2) begin
      report_failure($sformatf("frame count rose by %0d over two frames", delta));
    end
    finish_test(start_errors);
  endtask

  task automatic update_and_disable();
    pixel_t new_pix;
    wb_data_t status;
    int start_cycle;
    int waited;
    int start_errors;
    cur_test     = "disable and update";
    start_errors = errors;
    new_pix = pixel_t'($random(seed));
    write_word(pixel_base, {8'h00, new_pix});  // chain still running
    decode_frame(2, start_timeout);
    expect_equal("updated pixel 0", 32'(new_pix), 32'(rx_pix[0]));
    expect_equal("pixel 1", 32'h0000_ff00, 32'(rx_pix[1]));
    write_word(reg_ctrl, ctrl_word(1'b0, 8'd2));
    start_cycle = cycle;
    do begin
      read_word(reg_status, status);
    end while (status[status_busy_bit] && cycle - start_cycle <= frame_cycles(2) + gap_len);
    if (status[status_busy_bit]) begin
      report_failure("busy still high one frame and one gap after disable");
    end
    waited = 0;
    while (!ws2812 && waited < 2 * gap_len) begin
      @(negedge clk);
      waited++;
    end
    if (ws2812) begin
      report_failure("serial line active after disable");
    end
    finish_test(start_errors);
  endtask

  initial begin
    clk     = 1'b0;
    reset_n = 1'b0;
    wb_req  = '0;
    repeat (3) @(negedge clk);
    reset_n = 1'b1;
    access_registers();
    send_random_frame();
    measure_bit_timing();
    repeat_frames();
    update_and_disable();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: logic/led_pkg.sv
package led_pkg;

  // one LED colour, green in the top byte, then red, then blue
  typedef logic [23:0] pixel_t;
  typedef logic [7:0]  pixel_addr_t;   // LED index in the frame buffer
  typedef logic [7:0]  pixel_count_t;  // LEDs in the chain, 0 sends nothing
  typedef logic [15:0] frame_count_t;  // wrapping count of finished frames

  typedef logic [9:0]  wb_addr_t;      // word address
  typedef logic [31:0] wb_data_t;

  // register map, word addresses
  localparam wb_addr_t reg_ctrl   = 10'd0;
  localparam wb_addr_t reg_status = 10'd1;  // read only
  localparam wb_addr_t pixel_base = 10'd256;  // words 256..511 hold pixels 0..255

  // field positions
  localparam int ctrl_enable_bit  = 0;
  localparam int ctrl_count_lsb   = 8;
  localparam int status_busy_bit  = 0;
  localparam int status_frame_lsb = 16;

  typedef enum logic [2:0] {
    gap,       // line low between frames
    fetch,     // first pixel of a frame into the shifter
    bit_high,  // high phase of the current bit
    bit_low,   // low phase of the current bit
    next_bit   // advance to the next bit or pixel
  } tx_state_e;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_w;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat_r;
  } wb_rsp_t;

endpackage

// File: logic/led_strip_top.sv
`timescale 1ns/1ps

module led_strip_top #(
  parameter int clk_hz   = 27_000_000,
  parameter int reset_us = 300
) (
  input  logic             clk,
  input  logic             reset_n,
  input  led_pkg::wb_req_t wb_req,
  output led_pkg::wb_rsp_t wb_rsp,
  output logic             ws2812
);

  import led_pkg::*;

  logic         enable;
  pixel_count_t pixel_count;
  logic         busy;
  logic         frame_done;
  logic         wr_en;
  pixel_addr_t  wr_addr;
  pixel_t       wr_data;
  pixel_addr_t  rd_addr;
  pixel_t       rd_data;

  led_wb_slave i_slave (
    .clk         (clk),
    .reset_n     (reset_n),
    .wb_req      (wb_req),
    .busy        (busy),
    .frame_done  (frame_done),
    .wb_rsp      (wb_rsp),
    .enable      (enable),
    .pixel_count (pixel_count),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data)
  );

  pixel_ram i_ram (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  ws2812_transmitter #(
    .clk_hz   (clk_hz),
    .reset_us (reset_us)
  ) i_tx (
    .clk         (clk),
    .reset_n     (reset_n),
    .enable      (enable),
    .pixel_count (pixel_count),
    .rd_data     (rd_data),
    .rd_addr     (rd_addr),
    .ws2812      (ws2812),
    .busy        (busy),
    .frame_done  (frame_done)
  );

endmodule

// File: logic/led_wb_slave.sv
`timescale 1ns/1ps

module led_wb_slave (
  input  logic                  clk,
  input  logic                  reset_n,
  input  led_pkg::wb_req_t      wb_req,
  input  logic                  busy,
  input  logic                  frame_done,
  output led_pkg::wb_rsp_t      wb_rsp,
  output logic                  enable,
  output led_pkg::pixel_count_t pixel_count,
  output logic                  wr_en,
  output led_pkg::pixel_addr_t  wr_addr,
  output led_pkg::pixel_t       wr_data
);

  import led_pkg::*;

  logic         ack_q;
  logic         held;        // acked, waiting for stb to drop
  wb_data_t     dat_r_q;
  wb_data_t     rd_mux;
  frame_count_t frame_cnt;
  logic         access;
  logic         sel_ctrl;
  logic         sel_status;
  logic         sel_pixel;

  // a new cycle is only taken once stb has been low after the last ack
  assign access = wb_req.cyc && wb_req.stb && !held;

  assign sel_ctrl   = (wb_req.adr == reg_ctrl);
  assign sel_status = (wb_req.adr == reg_status);
  assign sel_pixel  = (wb_req.adr[9:8] == pixel_base[9:8]);  // 256..511

  // unmapped and pixel addresses read back as zero
  always_comb begin
    rd_mux = '0;
    if (sel_ctrl) begin
      rd_mux[ctrl_enable_bit] = enable;
      rd_mux[ctrl_count_lsb +: $bits(pixel_count_t)] = pixel_count;
    end else if (sel_status) begin
      rd_mux[status_busy_bit] = busy;
      rd_mux[status_frame_lsb +: $bits(frame_count_t)] = frame_cnt;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ack_q       <= 1'b0;
      held        <= 1'b0;
      enable      <= 1'b0;
      pixel_count <= '0;
      wr_en       <= 1'b0;
    end else begin
      ack_q <= access;
      wr_en <= access && wb_req.we && sel_pixel;  // one cycle strobe
      if (access) begin
        held <= 1'b1;
      end else if (!wb_req.stb) begin
        held <= 1'b0;
      end
      if (access && wb_req.we && sel_ctrl) begin
        enable      <= wb_req.dat_w[ctrl_enable_bit];
        pixel_count <= wb_req.dat_w[ctrl_count_lsb +: $bits(pixel_count_t)];
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      frame_cnt <= '0;
    end else if (frame_done) begin
      frame_cnt <= frame_cnt + 1'b1;  // wraps at 16 bits
    end
  end

  // read data and pixel write payload
  always_ff @(posedge clk) begin
    if (access) begin
      dat_r_q <= rd_mux;
      wr_addr <= wb_req.adr[7:0];
      wr_data <= wb_req.dat_w[23:0];
    end
  end

  assign wb_rsp = '{ack: ack_q, dat_r: dat_r_q};

endmodule

// File: logic/pixel_ram.sv
`timescale 1ns/1ps

module pixel_ram (
  input  logic                 clk,
  input  logic                 wr_en,
  input  led_pkg::pixel_addr_t wr_addr,
  input  led_pkg::pixel_t      wr_data,
  input  led_pkg::pixel_addr_t rd_addr,
  output led_pkg::pixel_t      rd_data
);

  import led_pkg::*;

  localparam int depth = 2 ** $bits(pixel_addr_t);  // one word per LED

  pixel_t mem [depth];

  // bus side
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // transmitter side, data one cycle after the address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: logic/ws2812_transmitter.sv
`timescale 1ns/1ps

module ws2812_transmitter #(
  parameter int clk_hz   = 27_000_000,
  parameter int reset_us = 300
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  enable,
  input  led_pkg::pixel_count_t pixel_count,
  input  led_pkg::pixel_t       rd_data,
  output led_pkg::pixel_addr_t  rd_addr,
  output logic                  ws2812,
  output logic                  busy,
  output logic                  frame_done
);

  import led_pkg::*;

  localparam real clk_mhz = clk_hz / 1.0e6;
  localparam int  t0h     = int'(0.40 * clk_mhz);  // ~400 ns
  localparam int  t1h     = int'(0.85 * clk_mhz);  // ~850 ns
  localparam int  t0l     = t1h;
  localparam int  t1l     = t0h;
  localparam int  gap_len = int'(reset_us * clk_mhz);
  localparam int  cnt_w   = $clog2(gap_len + 1);
  localparam int  bits_per_pixel = $bits(pixel_t);

  localparam logic [cnt_w-1:0] gap_last = cnt_w'(gap_len - 1);

  tx_state_e        state;
  logic [cnt_w-1:0] cnt;        // shared by gap and both bit phases
  logic [cnt_w-1:0] hi_last;
  logic [cnt_w-1:0] lo_last;
  pixel_t           shift;      // MSB is the bit on the line
  logic [4:0]       bit_idx;
  logic             run;        // frame allowed, taken at gap start
  pixel_count_t     frame_len;
  logic             last_bit;
  logic             last_pixel;

  // phase lengths depend on the bit being sent
  assign hi_last = shift[bits_per_pixel-1] ? cnt_w'(t1h - 1) : cnt_w'(t0h - 1);
  assign lo_last = shift[bits_per_pixel-1] ? cnt_w'(t1l - 1) : cnt_w'(t0l - 1);

  assign last_bit = (bit_idx == 5'(bits_per_pixel - 1));

  // rd_addr already points one past the pixel being shifted
  assign last_pixel = (rd_addr == pixel_addr_t'(frame_len));

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state      <= gap;
      cnt        <= '0;
      bit_idx    <= '0;
      rd_addr    <= '0;
      run        <= 1'b0;
      frame_len  <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      case (state)
        gap: begin
          if (cnt == '0) begin
            run       <= enable && (pixel_count != '0);
            frame_len <= pixel_count;
          end
          if (cnt == gap_last) begin
            cnt <= '0;  // restart the gap and sample again if idle
            if (run) begin
              state <= fetch;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end

        fetch: begin
          rd_addr <= rd_addr + 1'b1;  // next pixel address out early
          bit_idx <= '0;
          cnt     <= '0;
          state   <= bit_high;
        end

        bit_high: begin
          if (cnt == hi_last) begin
            cnt   <= '0;
            state <= bit_low;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end

        bit_low: begin
          if (cnt == lo_last) begin
            cnt   <= '0;
            state <= next_bit;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end

        next_bit: begin
          if (!last_bit) begin
            bit_idx <= bit_idx + 1'b1;
            state   <= bit_high;
          end else if (last_pixel) begin
            rd_addr    <= '0;
            frame_done <= 1'b1;
            state      <= gap;
          end else begin
            rd_addr <= rd_addr + 1'b1;
            bit_idx <= '0;
            state   <= bit_high;
          end
        end

        default: begin
          state <= gap;
        end
      endcase
    end
  end

  // pixel shifter, reloaded from the buffer at each pixel boundary
  always_ff @(posedge clk) begin
    if (state == fetch || (state == next_bit && last_bit)) begin
      shift <= rd_data;
    end else if (state == next_bit) begin
      shift <= shift << 1;
    end
  end

  assign ws2812 = (state == bit_high);
  assign busy   = (state != gap);

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module led_strip_tb -f build.f -o led_strip_sim \
  && ./obj_dir/led_strip_sim | tee /dev/stderr | grep -q "Regression passed" \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }
